// ==== Makefile ====
# Verilator simulation of the vector coprocessor

VERILATOR ?= verilator
TOP       ?= vec_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation OK"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+sim
source/vec_cfg_pkg.sv
source/vec_isa_pkg.sv
source/vec_dispatcher.sv
source/vec_sequencer.sv
source/vec_lane.sv
source/vec_masku.sv
source/vec_top.sv
sim/vec_tb.sv

// ==== sim/vec_tb_model.svh ====
// Vector coprocessor reference model
// Shadow copy of the register file, updated by every legal write,
// and the expected response of any request
`ifndef VEC_TB_MODEL_SVH
`define VEC_TB_MODEL_SVH

vec_cfg_pkg::elem_t shadow_vrf [vec_cfg_pkg::NrVRegs][VLMAX];

// Expected data and error, register file left untouched
function automatic vec_cfg_pkg::elem_t ref_result(
  input  vec_isa_pkg::vop_e  op,
  input  vec_cfg_pkg::vreg_t vs2,
  input  vec_cfg_pkg::elem_t rs1,
  input  vec_cfg_pkg::vl_t   vl,
  output logic               err
);
  vec_cfg_pkg::elem_t res;
  res = '0;
  err = (vl > VLMAX);
  if (!err) begin
    case (op)
      vec_isa_pkg::VREDSUM: for (int i = 0; i < vl; i++) res += shadow_vrf[vs2][i];
      vec_isa_pkg::VCPOP:   for (int i = 0; i < vl; i++) res += shadow_vrf[vs2][i][0];
      vec_isa_pkg::VEXT:    if (rs1 < vl) res = shadow_vrf[vs2][rs1];
      // Writes answer with zero
      default:              res = '0;
    endcase
  end
  return res;
endfunction

// Element-wise update of vd, tail elements untouched
task automatic apply_write(
  input vec_isa_pkg::vop_e  op,
  input vec_cfg_pkg::vreg_t vd,
  input vec_cfg_pkg::vreg_t vs1,
  input vec_cfg_pkg::vreg_t vs2,
  input vec_cfg_pkg::elem_t rs1,
  input vec_cfg_pkg::vl_t   vl
);
  if (vl <= VLMAX) begin
    for (int i = 0; i < vl; i++) begin
      case (op)
        vec_isa_pkg::VMV_VX:  shadow_vrf[vd][i] = rs1;
        vec_isa_pkg::VADD_VV: shadow_vrf[vd][i] = shadow_vrf[vs1][i] + shadow_vrf[vs2][i];
        vec_isa_pkg::VADD_VX: shadow_vrf[vd][i] = shadow_vrf[vs2][i] + rs1;
        default: ;
      endcase
    end
  end
endtask

`endif

// ==== sim/vec_tb.sv ====
// Vector coprocessor testbench
// Splats, additions, reductions, extracts and illegal lengths through
// the core request port, every response matched against the model
module vec_tb;

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemsPerLane = 4;
  localparam int unsigned VLMAX        = NrLanes * ElemsPerLane;
  // Cycles allowed for any single wait
  localparam int unsigned MaxWait      = 100;

  logic               clk_i = 1'b0;
  logic               rst_n_i;
  logic               acc_req_valid_i;
  logic               acc_req_ready_o;
  vec_isa_pkg::vop_e  acc_op_i;
  vec_cfg_pkg::vreg_t acc_vd_i;
  vec_cfg_pkg::vreg_t acc_vs1_i;
  vec_cfg_pkg::vreg_t acc_vs2_i;
  vec_cfg_pkg::elem_t acc_rs1_i;
  vec_cfg_pkg::vl_t   acc_vl_i;
  logic               acc_resp_valid_o;
  vec_cfg_pkg::elem_t acc_resp_data_o;
  logic               acc_resp_error_o;

  // Expected responses, oldest first
  string              exp_name_q [$];
  vec_cfg_pkg::elem_t exp_data_q [$];
  logic               exp_err_q  [$];

  `include "vec_tb_model.svh"

  vec_top #(
    .NrLanes      (NrLanes      ),
    .ElemsPerLane (ElemsPerLane )
  ) u_dut (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_op_i         (acc_op_i        ),
    .acc_vd_i         (acc_vd_i        ),
    .acc_vs1_i        (acc_vs1_i       ),
    .acc_vs2_i        (acc_vs2_i       ),
    .acc_rs1_i        (acc_rs1_i       ),
    .acc_vl_i         (acc_vl_i        ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_data_o  (acc_resp_data_o ),
    .acc_resp_error_o (acc_resp_error_o)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic check_data(input string name, input vec_cfg_pkg::elem_t exp,
                            input vec_cfg_pkg::elem_t act);
    if (act !== exp) begin
      $display("ERR %s expected %08h actual %08h", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_error(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected error %0b actual error %0b", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("test failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////
  // Core side of the request port
  ////////////////////////////////////////

  // Hold the request until valid and ready meet on an edge
  task automatic send_req(input vec_isa_pkg::vop_e op, input vec_cfg_pkg::vreg_t vd,
                          input vec_cfg_pkg::vreg_t vs1, input vec_cfg_pkg::vreg_t vs2,
                          input vec_cfg_pkg::elem_t rs1, input vec_cfg_pkg::vl_t vl);
    int unsigned cycles;
    cycles = 0;
    acc_req_valid_i <= 1'b1;
    acc_op_i        <= op;
    acc_vd_i        <= vd;
    acc_vs1_i       <= vs1;
    acc_vs2_i       <= vs2;
    acc_rs1_i       <= rs1;
    acc_vl_i        <= vl;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > MaxWait) stop_on_timeout("request ready");
    end while (!acc_req_ready_o);
    acc_req_valid_i <= 1'b0;
  endtask

  task automatic wait_resp();
    int unsigned cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > MaxWait) stop_on_timeout("response valid");
    end while (!acc_resp_valid_o);
  endtask

  // Expected value first, model update once the request is taken
  task automatic run_op(input string name, input vec_isa_pkg::vop_e op,
                        input vec_cfg_pkg::vreg_t vd, input vec_cfg_pkg::vreg_t vs1,
                        input vec_cfg_pkg::vreg_t vs2, input vec_cfg_pkg::elem_t rs1,
                        input vec_cfg_pkg::vl_t vl);
    vec_cfg_pkg::elem_t exp_data;
    logic               exp_err;
    exp_data = ref_result(op, vs2, rs1, vl, exp_err);
    exp_name_q.push_back(name);
    exp_data_q.push_back(exp_data);
    exp_err_q.push_back(exp_err);
    send_req(op, vd, vs1, vs2, rs1, vl);
    apply_write(op, vd, vs1, vs2, rs1, vl);
    wait_resp();
  endtask

  // Each response against the oldest expected entry
  always @(posedge clk_i) begin : compare_resp
    if (rst_n_i && acc_resp_valid_o) begin
      if (exp_data_q.size() == 0) begin
        $display("Response arrived with no request outstanding");
        $display("test failed");
        $fatal(1);
      end else begin
        check_error(exp_name_q[0], exp_err_q[0], acc_resp_error_o);
        check_data(exp_name_q[0], exp_data_q[0], acc_resp_data_o);
        exp_name_q.delete(0);
        exp_data_q.delete(0);
        exp_err_q.delete(0);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    vec_cfg_pkg::elem_t splat;
    vec_isa_pkg::vop_e  op;
    vec_cfg_pkg::vreg_t vd;
    vec_cfg_pkg::vreg_t vs1;
    vec_cfg_pkg::vreg_t vs2;
    vec_cfg_pkg::vl_t   vl;
    void'($urandom(4));
    rst_n_i         <= 1'b0;
    acc_req_valid_i <= 1'b0;
    acc_op_i        <= vec_isa_pkg::VMV_VX;
    acc_vd_i        <= '0;
    acc_vs1_i       <= '0;
    acc_vs2_i       <= '0;
    acc_rs1_i       <= '0;
    acc_vl_i        <= '0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    if (!acc_req_ready_o || acc_resp_valid_o) begin
      $display("Request ready low or response valid high after reset");
      $display("test failed");
      $fatal(1);
    end

    // Known contents everywhere before any arithmetic
    for (int r = 0; r < vec_cfg_pkg::NrVRegs; r++) begin
      run_op("init", vec_isa_pkg::VMV_VX, vec_cfg_pkg::vreg_t'(r), '0, '0, $urandom, VLMAX);
    end

    // Splat, then every index plus one past the end
    splat = $urandom;
    run_op("splat", vec_isa_pkg::VMV_VX, 3'd1, '0, '0, splat, VLMAX);
    for (int i = 0; i <= VLMAX; i++) begin
      run_op($sformatf("splat ext %0d", i), vec_isa_pkg::VEXT, '0, '0, 3'd1, i, VLMAX);
    end
    // Index inside the last walked slot but beyond vl
    run_op("ext past vl", vec_isa_pkg::VEXT, '0, '0, 3'd1, 32'd11, 8'd10);

    // Random additions, full readback shows the tail untouched
    repeat (24) begin
      op  = ($urandom % 2 == 0) ? vec_isa_pkg::VADD_VV : vec_isa_pkg::VADD_VX;
      vd  = vec_cfg_pkg::vreg_t'($urandom);
      vs1 = vec_cfg_pkg::vreg_t'($urandom);
      vs2 = vec_cfg_pkg::vreg_t'($urandom);
      vl  = vec_cfg_pkg::vl_t'($urandom % (VLMAX + 1));
      run_op("add", op, vd, vs1, vs2, $urandom, vl);
      for (int i = 0; i < VLMAX; i++) begin
        run_op($sformatf("add ext %0d", i), vec_isa_pkg::VEXT, '0, '0, vd, i, VLMAX);
      end
    end

    // Reductions, empty vectors included
    run_op("redsum vl 0", vec_isa_pkg::VREDSUM, '0, '0, 3'd2, '0, 8'd0);
    run_op("cpop vl 0", vec_isa_pkg::VCPOP, '0, '0, 3'd2, '0, 8'd0);
    repeat (20) begin
      vs2 = vec_cfg_pkg::vreg_t'($urandom);
      vl  = vec_cfg_pkg::vl_t'($urandom % (VLMAX + 1));
      run_op("redsum", vec_isa_pkg::VREDSUM, '0, '0, vs2, '0, vl);
      run_op("cpop", vec_isa_pkg::VCPOP, '0, '0, vs2, '0, vl);
    end

    // Over-long vectors are refused and leave vd alone
    vl = vec_cfg_pkg::vl_t'(VLMAX + 1 + ($urandom % (255 - VLMAX)));
    run_op("illegal splat", vec_isa_pkg::VMV_VX, 3'd4, '0, '0, $urandom, vl);
    run_op("illegal check", vec_isa_pkg::VREDSUM, '0, '0, 3'd4, '0, VLMAX);
    run_op("illegal redsum", vec_isa_pkg::VREDSUM, '0, '0, 3'd4, '0, 8'd255);

    // A few idle cycles so a stray response still reaches the compare process
    repeat (2) @(posedge clk_i);
    $display("test passed");
    $finish;
  end

endmodule

// ==== source/vec_cfg_pkg.sv ====
// Vector coprocessor configuration
// Datapath sizes of the element and the register file, and the
// storage types that every block builds its ports and state on
package vec_cfg_pkg;

  ////////////////////////////////////////
  // Datapath sizes
  ////////////////////////////////////////

  // One element, one word
  localparam int unsigned ElemWidth = 32;
  // Architectural vector registers
  localparam int unsigned NrVRegs   = 8;

  ////////////////////////////////////////
  // Storage types
  ////////////////////////////////////////

  typedef logic [ElemWidth-1:0] elem_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  // Vector length or element index
  typedef logic [7:0] vl_t;
  // Element slot inside one lane
  typedef logic [7:0] pe_idx_t;

endpackage

// ==== source/vec_dispatcher.sv ====
// Vector dispatcher
// Accepts one core request at a time, checks the vector length and
// issues legal instructions to the sequencer. Writes and illegal
// requests are answered at once, scalar results are forwarded from
// the mask unit.
module vec_dispatcher #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Core request
  input  logic                 acc_req_valid_i,
  output logic                 acc_req_ready_o,
  input  vec_isa_pkg::vop_e    acc_op_i,
  input  vec_cfg_pkg::vreg_t   acc_vd_i,
  input  vec_cfg_pkg::vreg_t   acc_vs1_i,
  input  vec_cfg_pkg::vreg_t   acc_vs2_i,
  input  vec_cfg_pkg::elem_t   acc_rs1_i,
  input  vec_cfg_pkg::vl_t     acc_vl_i,
  // Core response
  output logic                 acc_resp_valid_o,
  output vec_cfg_pkg::elem_t   acc_resp_data_o,
  output logic                 acc_resp_error_o,
  // Sequencer
  output logic                 issue_valid_o,
  output vec_isa_pkg::vop_e    op_o,
  output vec_cfg_pkg::vreg_t   vd_o,
  output vec_cfg_pkg::vreg_t   vs1_o,
  output vec_cfg_pkg::vreg_t   vs2_o,
  output vec_cfg_pkg::elem_t   rs1_o,
  output vec_cfg_pkg::vl_t     vl_o,
  input  logic                 seq_done_i,
  // Mask unit
  input  logic                 result_valid_i,
  input  vec_cfg_pkg::elem_t   result_i
);

  localparam int unsigned VLMAX = NrLanes * ElemsPerLane;

  logic pending_q;
  logic accept;
  logic illegal;

  assign acc_req_ready_o = !pending_q;
  assign accept          = acc_req_valid_i && acc_req_ready_o;
  assign illegal         = acc_vl_i > VLMAX;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q        <= 1'b0;
      issue_valid_o    <= 1'b0;
      acc_resp_valid_o <= 1'b0;
      acc_resp_error_o <= 1'b0;
    end else begin
      issue_valid_o    <= accept && !illegal;
      // Immediate answer, or the scalar coming back from the mask unit
      acc_resp_valid_o <= (accept && (illegal || !vec_isa_pkg::is_scalar_result(acc_op_i))) ||
                          (pending_q && result_valid_i);
      if (accept) begin
        pending_q        <= 1'b1;
        acc_resp_error_o <= illegal;
      end else if (seq_done_i || (acc_resp_valid_o && acc_resp_error_o)) begin
        // Illegal requests never reach the sequencer
        pending_q <= 1'b0;
      end
    end
  end

  // Instruction fields and response data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_o            <= acc_op_i;
      vd_o            <= acc_vd_i;
      vs1_o           <= acc_vs1_i;
      vs2_o           <= acc_vs2_i;
      rs1_o           <= acc_rs1_i;
      vl_o            <= acc_vl_i;
      acc_resp_data_o <= '0;
    end else if (result_valid_i) begin
      acc_resp_data_o <= result_i;
    end
  end

  // Core sees at most one response per instruction
  a_resp_spaced: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o |=> !acc_resp_valid_o);

endmodule

// ==== source/vec_isa_pkg.sv ====
// Vector coprocessor instruction set
// Operation encoding shared by the core interface and all processing
// elements, plus helpers that classify an operation by its result
package vec_isa_pkg;

  typedef enum logic [2:0] {
    VMV_VX  = 3'd0,
    VADD_VV = 3'd1,
    VADD_VX = 3'd2,
    VREDSUM = 3'd3,
    VCPOP   = 3'd4,
    VEXT    = 3'd5
  } vop_e;

  ////////////////////////////////////////
  // Classification
  ////////////////////////////////////////

  // Scalar result goes back to the core through the mask unit
  function automatic logic is_scalar_result(vop_e op);
    return op inside {VREDSUM, VCPOP, VEXT};
  endfunction

  // Element-wise ops that update vd
  function automatic logic writes_vd(vop_e op);
    return op inside {VMV_VX, VADD_VV, VADD_VX};
  endfunction

endpackage

// ==== source/vec_lane.sv ====
// Vector lane
// Holds this lane's slice of the vector register file and walks its
// element slots one per cycle, writing element-wise results into vd or
// presenting vs2 elements to the mask unit
module vec_lane #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4,
  parameter int unsigned LaneIdx      = 0
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Sequencer broadcast
  input  logic                 pe_req_valid_i,
  input  vec_isa_pkg::vop_e    pe_op_i,
  input  vec_cfg_pkg::vreg_t   pe_vd_i,
  input  vec_cfg_pkg::vreg_t   pe_vs1_i,
  input  vec_cfg_pkg::vreg_t   pe_vs2_i,
  input  vec_cfg_pkg::elem_t   pe_rs1_i,
  input  vec_cfg_pkg::vl_t     pe_vl_i,
  output logic                 lane_done_o,
  // Mask unit
  output logic                 operand_valid_o,
  output vec_cfg_pkg::elem_t   operand_o
);

  localparam int unsigned VrfDepth  = vec_cfg_pkg::NrVRegs * ElemsPerLane;
  localparam int unsigned AddrWidth = $clog2(VrfDepth);

  vec_cfg_pkg::elem_t vrf [VrfDepth];

  logic                 active_q;
  vec_cfg_pkg::pe_idx_t slot_q;
  vec_isa_pkg::vop_e    op_q;
  vec_cfg_pkg::vreg_t   vd_q;
  vec_cfg_pkg::vreg_t   vs1_q;
  vec_cfg_pkg::vreg_t   vs2_q;
  vec_cfg_pkg::elem_t   rs1_q;
  vec_cfg_pkg::vl_t     vl_q;

  vec_cfg_pkg::pe_idx_t nr_slots;
  vec_cfg_pkg::elem_t   elem_idx;
  logic                 elem_act;
  logic                 last_slot;
  logic [AddrWidth-1:0] vd_addr;
  logic [AddrWidth-1:0] vs1_addr;
  logic [AddrWidth-1:0] vs2_addr;
  vec_cfg_pkg::elem_t   alu_res;

  ////////////////////////////////////////
  // Slot walk and element-wise ALU
  ////////////////////////////////////////

  always_comb begin
    // ceil(vl / NrLanes) slots, same for every lane
    nr_slots  = vec_cfg_pkg::pe_idx_t'((vl_q + NrLanes - 1) / NrLanes);
    elem_idx  = slot_q * NrLanes + LaneIdx;
    elem_act  = elem_idx < vl_q;
    last_slot = (nr_slots == '0) || (slot_q == nr_slots - 1'b1);
    vd_addr   = AddrWidth'(vd_q * ElemsPerLane + slot_q);
    vs1_addr  = AddrWidth'(vs1_q * ElemsPerLane + slot_q);
    vs2_addr  = AddrWidth'(vs2_q * ElemsPerLane + slot_q);
    case (op_q)
      vec_isa_pkg::VMV_VX:  alu_res = rs1_q;
      vec_isa_pkg::VADD_VV: alu_res = vrf[vs1_addr] + vrf[vs2_addr];
      vec_isa_pkg::VADD_VX: alu_res = vrf[vs2_addr] + rs1_q;
      default:              alu_res = vrf[vs2_addr];
    endcase
  end

  assign lane_done_o     = active_q && last_slot;
  // Reductions take every active element, extract only the selected one
  assign operand_valid_o = active_q && elem_act &&
                           ((op_q inside {vec_isa_pkg::VREDSUM, vec_isa_pkg::VCPOP}) ||
                            (op_q == vec_isa_pkg::VEXT && elem_idx == rs1_q));
  assign operand_o       = vrf[vs2_addr];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      slot_q   <= '0;
    end else if (pe_req_valid_i) begin
      active_q <= 1'b1;
      slot_q   <= '0;
    end else if (active_q) begin
      if (last_slot) begin
        active_q <= 1'b0;
      end else begin
        slot_q <= slot_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) begin
      op_q  <= pe_op_i;
      vd_q  <= pe_vd_i;
      vs1_q <= pe_vs1_i;
      vs2_q <= pe_vs2_i;
      rs1_q <= pe_rs1_i;
      vl_q  <= pe_vl_i;
    end
    // Tail elements keep their old value
    if (active_q && elem_act && vec_isa_pkg::writes_vd(op_q)) begin
      vrf[vd_addr] <= alu_res;
    end
  end

  // One instruction in flight across the whole coprocessor
  a_no_req_active: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pe_req_valid_i |-> !active_q);

endmodule

// ==== source/vec_masku.sv ====
// Vector mask unit
// Folds the operands that all lanes present each cycle into one scalar:
// a sum for reductions, a count of odd elements, or the single element
// picked by an extract
module vec_masku #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Sequencer broadcast
  input  logic                              pe_req_valid_i,
  input  vec_isa_pkg::vop_e                 pe_op_i,
  // Lanes
  input  logic [NrLanes-1:0]                lane_done_i,
  input  logic [NrLanes-1:0]                operand_valid_i,
  input  vec_cfg_pkg::elem_t [NrLanes-1:0]  operand_i,
  // Scalar result
  output logic                              result_valid_o,
  output vec_cfg_pkg::elem_t                result_o
);

  logic               active_q;
  logic [NrLanes-1:0] done_q;
  logic               all_done;
  vec_isa_pkg::vop_e  op_q;
  vec_cfg_pkg::elem_t acc_q;
  vec_cfg_pkg::elem_t acc_d;

  assign all_done = &(done_q | lane_done_i);
  assign result_o = acc_q;

  // All lanes consumed in the cycle they appear
  always_comb begin
    acc_d = acc_q;
    for (int l = 0; l < NrLanes; l++) begin
      if (operand_valid_i[l]) begin
        case (op_q)
          vec_isa_pkg::VREDSUM: acc_d = acc_d + operand_i[l];
          vec_isa_pkg::VCPOP:   acc_d = acc_d + vec_cfg_pkg::elem_t'(operand_i[l][0]);
          default:              acc_d = operand_i[l];
        endcase
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q       <= 1'b0;
      done_q         <= '0;
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= active_q && all_done;
      if (pe_req_valid_i && vec_isa_pkg::is_scalar_result(pe_op_i)) begin
        active_q <= 1'b1;
        done_q   <= '0;
      end else if (active_q) begin
        done_q <= done_q | lane_done_i;
        if (all_done) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  // Accumulator starts from zero, so an empty vector gives 0
  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) begin
      op_q  <= pe_op_i;
      acc_q <= '0;
    end else if (active_q) begin
      acc_q <= acc_d;
    end
  end

  // Lanes only feed operands for a scalar instruction
  a_no_operand_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|operand_valid_i) |-> active_q);

endmodule

// ==== source/vec_sequencer.sv ====
// Vector sequencer
// Registers the issued instruction, broadcasts it to all lanes and
// the mask unit, and reports completion once every lane is done and
// any scalar result has been produced
module vec_sequencer #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Dispatcher
  input  logic                 issue_valid_i,
  input  vec_isa_pkg::vop_e    op_i,
  input  vec_cfg_pkg::vreg_t   vd_i,
  input  vec_cfg_pkg::vreg_t   vs1_i,
  input  vec_cfg_pkg::vreg_t   vs2_i,
  input  vec_cfg_pkg::elem_t   rs1_i,
  input  vec_cfg_pkg::vl_t     vl_i,
  output logic                 seq_done_o,
  // Processing elements
  output logic                 pe_req_valid_o,
  output vec_isa_pkg::vop_e    pe_op_o,
  output vec_cfg_pkg::vreg_t   pe_vd_o,
  output vec_cfg_pkg::vreg_t   pe_vs1_o,
  output vec_cfg_pkg::vreg_t   pe_vs2_o,
  output vec_cfg_pkg::elem_t   pe_rs1_o,
  output vec_cfg_pkg::vl_t     pe_vl_o,
  input  logic [NrLanes-1:0]   lane_done_i,
  input  logic                 result_valid_i
);

  logic               busy_q;
  logic               res_seen_q;
  logic [NrLanes-1:0] done_q;
  logic               all_done;

  // Sticky done bits plus this cycle's pulses
  assign all_done = busy_q && !pe_req_valid_o && (&(done_q | lane_done_i)) &&
                    (!vec_isa_pkg::is_scalar_result(pe_op_o) || res_seen_q || result_valid_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q         <= 1'b0;
      res_seen_q     <= 1'b0;
      done_q         <= '0;
      pe_req_valid_o <= 1'b0;
      seq_done_o     <= 1'b0;
    end else begin
      pe_req_valid_o <= issue_valid_i;
      seq_done_o     <= all_done;
      if (issue_valid_i) begin
        busy_q <= 1'b1;
      end else if (all_done) begin
        busy_q     <= 1'b0;
        res_seen_q <= 1'b0;
        done_q     <= '0;
      end else if (busy_q) begin
        res_seen_q <= res_seen_q | result_valid_i;
        done_q     <= done_q | lane_done_i;
      end
    end
  end

  // Broadcast fields
  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      pe_op_o  <= op_i;
      pe_vd_o  <= vd_i;
      pe_vs1_o <= vs1_i;
      pe_vs2_o <= vs2_i;
      pe_rs1_o <= rs1_i;
      pe_vl_o  <= vl_i;
    end
  end

  // Dispatcher holds back while an instruction is in flight
  a_no_issue_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_i |-> !busy_q);

endmodule

// ==== source/vec_top.sv ====
// Vector coprocessor top level
// Core-facing dispatcher, in-order sequencer, an array of lanes that
// each own an interleaved slice of the register file, and the mask
// unit that produces scalar results
module vec_top #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Core request
  input  logic                 acc_req_valid_i,
  output logic                 acc_req_ready_o,
  input  vec_isa_pkg::vop_e    acc_op_i,
  input  vec_cfg_pkg::vreg_t   acc_vd_i,
  input  vec_cfg_pkg::vreg_t   acc_vs1_i,
  input  vec_cfg_pkg::vreg_t   acc_vs2_i,
  input  vec_cfg_pkg::elem_t   acc_rs1_i,
  input  vec_cfg_pkg::vl_t     acc_vl_i,
  // Core response
  output logic                 acc_resp_valid_o,
  output vec_cfg_pkg::elem_t   acc_resp_data_o,
  output logic                 acc_resp_error_o
);

  // Dispatcher to sequencer
  logic                              issue_valid;
  vec_isa_pkg::vop_e                 issue_op;
  vec_cfg_pkg::vreg_t                issue_vd;
  vec_cfg_pkg::vreg_t                issue_vs1;
  vec_cfg_pkg::vreg_t                issue_vs2;
  vec_cfg_pkg::elem_t                issue_rs1;
  vec_cfg_pkg::vl_t                  issue_vl;
  logic                              seq_done;
  // Sequencer broadcast
  logic                              pe_req_valid;
  vec_isa_pkg::vop_e                 pe_op;
  vec_cfg_pkg::vreg_t                pe_vd;
  vec_cfg_pkg::vreg_t                pe_vs1;
  vec_cfg_pkg::vreg_t                pe_vs2;
  vec_cfg_pkg::elem_t                pe_rs1;
  vec_cfg_pkg::vl_t                  pe_vl;
  // Lanes and mask unit
  logic [NrLanes-1:0]                lane_done;
  logic [NrLanes-1:0]                operand_valid;
  vec_cfg_pkg::elem_t [NrLanes-1:0]  operand;
  logic                              result_valid;
  vec_cfg_pkg::elem_t                result;

  vec_dispatcher #(
    .NrLanes      (NrLanes      ),
    .ElemsPerLane (ElemsPerLane )
  ) i_dispatcher (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_op_i         (acc_op_i        ),
    .acc_vd_i         (acc_vd_i        ),
    .acc_vs1_i        (acc_vs1_i       ),
    .acc_vs2_i        (acc_vs2_i       ),
    .acc_rs1_i        (acc_rs1_i       ),
    .acc_vl_i         (acc_vl_i        ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_data_o  (acc_resp_data_o ),
    .acc_resp_error_o (acc_resp_error_o),
    .issue_valid_o    (issue_valid     ),
    .op_o             (issue_op        ),
    .vd_o             (issue_vd        ),
    .vs1_o            (issue_vs1       ),
    .vs2_o            (issue_vs2       ),
    .rs1_o            (issue_rs1       ),
    .vl_o             (issue_vl        ),
    .seq_done_i       (seq_done        ),
    .result_valid_i   (result_valid    ),
    .result_i         (result          )
  );

  vec_sequencer #(
    .NrLanes (NrLanes)
  ) i_sequencer (
    .clk_i          (clk_i        ),
    .rst_n_i        (rst_n_i      ),
    .issue_valid_i  (issue_valid  ),
    .op_i           (issue_op     ),
    .vd_i           (issue_vd     ),
    .vs1_i          (issue_vs1    ),
    .vs2_i          (issue_vs2    ),
    .rs1_i          (issue_rs1    ),
    .vl_i           (issue_vl     ),
    .seq_done_o     (seq_done     ),
    .pe_req_valid_o (pe_req_valid ),
    .pe_op_o        (pe_op        ),
    .pe_vd_o        (pe_vd        ),
    .pe_vs1_o       (pe_vs1       ),
    .pe_vs2_o       (pe_vs2       ),
    .pe_rs1_o       (pe_rs1       ),
    .pe_vl_o        (pe_vl        ),
    .lane_done_i    (lane_done    ),
    .result_valid_i (result_valid )
  );

  ////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lanes
    vec_lane #(
      .NrLanes      (NrLanes      ),
      .ElemsPerLane (ElemsPerLane ),
      .LaneIdx      (lane         )
    ) i_lane (
      .clk_i           (clk_i               ),
      .rst_n_i         (rst_n_i             ),
      .pe_req_valid_i  (pe_req_valid        ),
      .pe_op_i         (pe_op               ),
      .pe_vd_i         (pe_vd               ),
      .pe_vs1_i        (pe_vs1              ),
      .pe_vs2_i        (pe_vs2              ),
      .pe_rs1_i        (pe_rs1              ),
      .pe_vl_i         (pe_vl               ),
      .lane_done_o     (lane_done[lane]     ),
      .operand_valid_o (operand_valid[lane] ),
      .operand_o       (operand[lane]       )
    );
  end : gen_lanes

  vec_masku #(
    .NrLanes (NrLanes)
  ) i_masku (
    .clk_i           (clk_i         ),
    .rst_n_i         (rst_n_i       ),
    .pe_req_valid_i  (pe_req_valid  ),
    .pe_op_i         (pe_op         ),
    .lane_done_i     (lane_done     ),
    .operand_valid_i (operand_valid ),
    .operand_i       (operand       ),
    .result_valid_o  (result_valid  ),
    .result_o        (result        )
  );

endmodule
